// ==== filelist.f ====
+incdir+include
verilog/moxie_pkg.sv
verilog/moxie_regfile.sv
verilog/moxie_decode.sv
verilog/moxie_execute.sv
verilog/moxie_memory.sv
verilog/moxie_core.sv
tests/moxie_core_tb.sv

// ==== include/moxie_cfg.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// Moxie back end configuration
// Widths and sizes shared by the core and its types
// ~~~~~~~~~~~~~~~~~~~~

`ifndef MOXIE_CFG_SVH
`define MOXIE_CFG_SVH

// Data and address width
`define MOXIE_XLEN 32

// Register file size and index width
`define MOXIE_NREGS 16
`define MOXIE_RIDX_W 4

// Branch offset width, in halfwords
`define MOXIE_PCREL_W 10

// Size of one instruction slot, added to pc for relative branches
`define MOXIE_PC_STEP 2

`endif

// ==== tests/moxie_core_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Moxie back end testbench
// Directed tests with a Wishbone slave memory, a reference
// register model and store and branch logs
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "moxie_cfg.svh"

module moxie_core_tb;

  localparam int MEM_WORDS = 64;

  logic                   clk_i;
  logic                   rst_i;
  logic                   instr_valid_i;
  moxie_pkg::instr_t      instr_i;
  logic                   instr_ready_o;
  moxie_pkg::branch_t     branch_o;
  logic                   wb_cyc_o;
  logic                   wb_stb_o;
  logic                   wb_we_o;
  logic [`MOXIE_XLEN-1:0] wb_adr_o;
  logic [`MOXIE_XLEN-1:0] wb_dat_o;
  logic                   wb_ack_i = 1'b0;
  logic [`MOXIE_XLEN-1:0] wb_dat_i = '0;

  // Slave memory and its mirror as the reference model sees it at issue
  logic [31:0]    bus_mem [MEM_WORDS];
  logic [31:0]    ref_mem [MEM_WORDS];
  logic [31:0]    ref_regs [`MOXIE_NREGS];
  moxie_pkg::cc_t ref_cc;
  logic           ref_kill = 1'b0;
  logic [31:0]    pc_q = 32'h0000_1000;

  integer seed = 32'h8ca3cbba;
  integer ack_delay_force = -1;
  integer wait_left = 0;
  logic   in_cycle = 1'b0;
  integer cycles = 0;
  integer n_issued = 0;
  integer n_tests = 0;
  integer n_errors = 0;
  integer test_errors = 0;
  logic   ready_min = 1'b1;
  string  test_name = "none";

  logic [31:0]        store_adr_q [$];
  logic [31:0]        store_dat_q [$];
  logic [31:0]        exp_adr_q [$];
  logic [31:0]        exp_dat_q [$];
  moxie_pkg::branch_t branch_q [$];
  moxie_pkg::branch_t exp_branch_q [$];

  moxie_core u_dut (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .branch_o      (branch_o),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_we_o       (wb_we_o),
    .wb_adr_o      (wb_adr_o),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_i      (wb_ack_i),
    .wb_dat_i      (wb_dat_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Budget of 40 cycles per issued instruction on top of a fixed margin
  always @(posedge clk_i)
  begin
    cycles = cycles + 1;
    if (cycles > 40 * n_issued + 400)
    begin
      $display("Timeout in test %s: no progress after %0d cycles", test_name, cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Wishbone slave that acks after 0 to 3 wait cycles unless forced
  always @(negedge clk_i)
  begin
    if (wb_ack_i)
    begin
      wb_ack_i = 1'b0;
    end
    else if (wb_cyc_o && wb_stb_o)
    begin
      if (!in_cycle)
      begin
        in_cycle  = 1'b1;
        wait_left = (ack_delay_force >= 0) ? ack_delay_force : $unsigned($random(seed)) % 4;
      end
      if (wait_left == 0)
      begin
        in_cycle = 1'b0;
        wb_ack_i = 1'b1;
        if (wb_we_o)
        begin
          bus_mem[wb_adr_o[7:2]] = wb_dat_o;
          store_adr_q.push_back(wb_adr_o);
          store_dat_q.push_back(wb_dat_o);
        end
        else
        begin
          wb_dat_i = bus_mem[wb_adr_o[7:2]];
        end
      end
      else
      begin
        wait_left = wait_left - 1;
      end
    end
  end

  always @(negedge clk_i)
  begin
    if (branch_o.valid === 1'b1)
      branch_q.push_back(branch_o);
  end

  task automatic check_store(input logic [31:0] exp_adr, input logic [31:0] exp_dat,
                             input logic [31:0] act_adr, input logic [31:0] act_dat);
    begin
      if ((exp_adr !== act_adr) || (exp_dat !== act_dat))
      begin
        $display("Mismatch %s: expected store %08h <- %08h, actual %08h <- %08h",
                 test_name, exp_adr, exp_dat, act_adr, act_dat);
        test_errors = test_errors + 1;
      end
    end
  endtask

  task automatic check_branch(input moxie_pkg::branch_t exp, input moxie_pkg::branch_t act);
    begin
      if (exp !== act)
      begin
        $display("Mismatch %s: expected branch %b/%08h, actual %b/%08h",
                 test_name, exp.valid, exp.target, act.valid, act.target);
        test_errors = test_errors + 1;
      end
    end
  endtask

  task automatic check_ready(input logic exp, input logic act);
    begin
      if (exp !== act)
      begin
        $display("Mismatch %s: expected ready %b, actual %b", test_name, exp, act);
        test_errors = test_errors + 1;
      end
    end
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    begin
      if (exp !== act)
      begin
        $display("Mismatch %s: expected %s %b, actual %b", test_name, what, exp, act);
        test_errors = test_errors + 1;
      end
    end
  endtask

  // Reference behavior of one issued instruction including the shadow squash
  task automatic model_step(input moxie_pkg::instr_t ins);
    logic [31:0]        a;
    logic [31:0]        b;
    logic signed [31:0] off;
    logic               taken;
    moxie_pkg::branch_t br;
    begin
      a     = ref_regs[ins.ra];
      b     = ref_regs[ins.rb];
      off   = $signed(ins.imm[9:0]);
      taken = 1'b0;
      br.valid  = 1'b1;
      br.target = ins.pc + 32'd2 + off * 2;
      if (ref_kill)
      begin
        ref_kill = 1'b0;
      end
      else
      begin
        case (ins.op)
          moxie_pkg::OP_ADD_L: ref_regs[ins.ra] = a + b;
          moxie_pkg::OP_SUB_L: ref_regs[ins.ra] = a - b;
          moxie_pkg::OP_AND:   ref_regs[ins.ra] = a & b;
          moxie_pkg::OP_OR:    ref_regs[ins.ra] = a | b;
          moxie_pkg::OP_XOR:   ref_regs[ins.ra] = a ^ b;
          moxie_pkg::OP_MOV:   ref_regs[ins.ra] = b;
          moxie_pkg::OP_LDI_L: ref_regs[ins.ra] = ins.imm;
          moxie_pkg::OP_INC:   ref_regs[ins.ra] = a + ins.imm;
          moxie_pkg::OP_DEC:   ref_regs[ins.ra] = a - ins.imm;
          moxie_pkg::OP_LDA_L: ref_regs[ins.ra] = ref_mem[ins.imm[7:2]];
          moxie_pkg::OP_STA_L:
          begin
            ref_mem[ins.imm[7:2]] = a;
            exp_adr_q.push_back(ins.imm);
            exp_dat_q.push_back(a);
          end
          moxie_pkg::OP_CMP:
          begin
            ref_cc.eq  = a == b;
            ref_cc.lt  = $signed(a) < $signed(b);
            ref_cc.gt  = $signed(a) > $signed(b);
            ref_cc.ltu = a < b;
            ref_cc.gtu = a > b;
          end
          moxie_pkg::OP_BEQ:  taken = ref_cc.eq;
          moxie_pkg::OP_BNE:  taken = !ref_cc.eq;
          moxie_pkg::OP_BLT:  taken = ref_cc.lt;
          moxie_pkg::OP_BGT:  taken = ref_cc.gt;
          moxie_pkg::OP_BLTU: taken = ref_cc.ltu;
          moxie_pkg::OP_BGTU: taken = ref_cc.gtu;
          moxie_pkg::OP_JMPA:
          begin
            taken     = 1'b1;
            br.target = ins.imm;
          end
          default: ;
        endcase
        if (taken)
        begin
          exp_branch_q.push_back(br);
          ref_kill = 1'b1;
        end
      end
    end
  endtask

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic issue(input moxie_pkg::opcode_e op, input logic [3:0] ra,
                       input logic [3:0] rb, input logic [31:0] imm);
    moxie_pkg::instr_t ins;
    begin
      ins.op  = op;
      ins.ra  = ra;
      ins.rb  = rb;
      ins.imm = imm;
      ins.pc  = pc_q;
      instr_i       = ins;
      instr_valid_i = 1'b1;
      #1;
      while (!instr_ready_o)
      begin
        ready_min = 1'b0;
        @(negedge clk_i);
        #1;
      end
      @(negedge clk_i);
      instr_valid_i = 1'b0;
      n_issued      = n_issued + 1;
      pc_q          = pc_q + 32'd2;
      model_step(ins);
    end
  endtask

  task automatic start_test(input string name);
    begin
      test_name   = name;
      test_errors = 0;
      ready_min   = 1'b1;
    end
  endtask

  // Waits for all expected stores and then compares both logs in order
  task automatic finish_test;
    integer i;
    begin
      while (store_adr_q.size() < exp_adr_q.size())
        @(negedge clk_i);
      if (store_adr_q.size() != exp_adr_q.size())
      begin
        $display("Test %s saw %0d stores where %0d were expected",
                 test_name, store_adr_q.size(), exp_adr_q.size());
        test_errors = test_errors + 1;
      end
      for (i = 0; i < exp_adr_q.size(); i++)
        check_store(exp_adr_q[i], exp_dat_q[i], store_adr_q[i], store_dat_q[i]);
      if (branch_q.size() != exp_branch_q.size())
      begin
        $display("Test %s saw %0d taken branches where %0d were expected",
                 test_name, branch_q.size(), exp_branch_q.size());
        test_errors = test_errors + 1;
      end
      else
      begin
        for (i = 0; i < exp_branch_q.size(); i++)
          check_branch(exp_branch_q[i], branch_q[i]);
      end
      $display("Test %s: %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "failed",
               test_errors);
      n_errors = n_errors + test_errors;
      n_tests  = n_tests + 1;
      store_adr_q.delete();
      store_dat_q.delete();
      exp_adr_q.delete();
      exp_dat_q.delete();
      branch_q.delete();
      exp_branch_q.delete();
    end
  endtask

  task automatic preload(input logic [31:0] adr, input logic [31:0] value);
    begin
      bus_mem[adr[7:2]] = value;
      ref_mem[adr[7:2]] = value;
    end
  endtask

  // Copy r1, combine it with r2 and store the result
  task automatic alu_case(input moxie_pkg::opcode_e op, input logic [31:0] adr);
    begin
      issue(moxie_pkg::OP_MOV, 3, 1, 0);
      issue(op, 3, 2, 0);
      issue(moxie_pkg::OP_STA_L, 3, 0, adr);
    end
  endtask

  task automatic branch_case(input moxie_pkg::opcode_e op, input logic [3:0] ra,
                             input logic [3:0] rb, input logic [31:0] off,
                             input logic [31:0] adr);
    begin
      issue(moxie_pkg::OP_CMP, ra, rb, 0);
      issue(op, 0, 0, off);
      issue(moxie_pkg::OP_STA_L, 7, 0, adr);
    end
  endtask

  task automatic reset_state;
    moxie_pkg::branch_t idle_br;
    begin
      start_test("reset");
      idle_br = '0;
      #1;
      compare_bit("cyc", 1'b0, wb_cyc_o);
      compare_bit("stb", 1'b0, wb_stb_o);
      check_branch(idle_br, branch_o);
      check_ready(1'b1, instr_ready_o);
      @(negedge clk_i);
      finish_test();
    end
  endtask

  task automatic alu_ops;
    begin
      start_test("alu");
      issue(moxie_pkg::OP_LDI_L, 1, 0, 32'h8765_4321);
      issue(moxie_pkg::OP_LDI_L, 2, 0, 32'h0ff0_1234);
      alu_case(moxie_pkg::OP_ADD_L, 32'h40);
      alu_case(moxie_pkg::OP_SUB_L, 32'h44);
      alu_case(moxie_pkg::OP_AND, 32'h48);
      alu_case(moxie_pkg::OP_OR, 32'h4c);
      alu_case(moxie_pkg::OP_XOR, 32'h50);
      issue(moxie_pkg::OP_MOV, 4, 2, 0);
      issue(moxie_pkg::OP_STA_L, 4, 0, 32'h54);
      issue(moxie_pkg::OP_INC, 4, 0, 32'h0000_01ff);
      issue(moxie_pkg::OP_STA_L, 4, 0, 32'h58);
      issue(moxie_pkg::OP_DEC, 4, 0, 32'h1000_0003);
      issue(moxie_pkg::OP_STA_L, 4, 0, 32'h5c);
      finish_test();
    end
  endtask

  task automatic load_store;
    begin
      start_test("load");
      preload(32'h80, 32'hdead_beef);
      issue(moxie_pkg::OP_LDA_L, 5, 0, 32'h80);
      issue(moxie_pkg::OP_STA_L, 5, 0, 32'h84);
      issue(moxie_pkg::OP_LDA_L, 6, 0, 32'h88);
      issue(moxie_pkg::OP_INC, 6, 0, 32'h1);
      issue(moxie_pkg::OP_STA_L, 6, 0, 32'h8c);
      finish_test();
    end
  endtask

  task automatic cond_branches;
    begin
      start_test("branch");
      issue(moxie_pkg::OP_LDI_L, 7, 0, 32'h5);
      issue(moxie_pkg::OP_LDI_L, 8, 0, 32'h5);
      issue(moxie_pkg::OP_LDI_L, 9, 0, 32'hffff_fff0);
      issue(moxie_pkg::OP_LDI_L, 10, 0, 32'h0000_0010);
      // Equal operands
      branch_case(moxie_pkg::OP_BEQ, 7, 8, 32'h010, 32'ha0);
      branch_case(moxie_pkg::OP_BNE, 7, 8, 32'h010, 32'ha4);
      branch_case(moxie_pkg::OP_BLT, 7, 8, 32'h3f0, 32'ha8);
      branch_case(moxie_pkg::OP_BGTU, 7, 8, 32'h3f0, 32'hac);
      // Negative against positive where signed and unsigned orders disagree
      branch_case(moxie_pkg::OP_BLT, 9, 10, 32'h3fc, 32'hb0);
      branch_case(moxie_pkg::OP_BGT, 9, 10, 32'h1ff, 32'hb4);
      branch_case(moxie_pkg::OP_BLTU, 9, 10, 32'h200, 32'hb8);
      branch_case(moxie_pkg::OP_BGTU, 9, 10, 32'h200, 32'hbc);
      branch_case(moxie_pkg::OP_BGT, 10, 9, 32'h001, 32'hc0);
      branch_case(moxie_pkg::OP_BLTU, 10, 9, 32'h3ff, 32'hc4);
      branch_case(moxie_pkg::OP_BEQ, 10, 9, 32'h001, 32'hc8);
      issue(moxie_pkg::OP_STA_L, 8, 0, 32'hfc);
      finish_test();
    end
  endtask

  task automatic jumps;
    begin
      start_test("jump");
      issue(moxie_pkg::OP_JMPA, 0, 0, 32'h0000_2468);
      issue(moxie_pkg::OP_LDI_L, 7, 0, 32'h99);
      issue(moxie_pkg::OP_STA_L, 7, 0, 32'hd0);
      issue(moxie_pkg::OP_JMPA, 0, 0, 32'h8000_0100);
      // Shadow is squashed even after idle cycles
      repeat (3) @(negedge clk_i);
      issue(moxie_pkg::OP_STA_L, 7, 0, 32'hd4);
      issue(moxie_pkg::OP_STA_L, 8, 0, 32'hd8);
      finish_test();
    end
  endtask

  task automatic backpressure;
    begin
      start_test("backpressure");
      ack_delay_force = 8;
      issue(moxie_pkg::OP_STA_L, 1, 0, 32'he0);
      issue(moxie_pkg::OP_STA_L, 2, 0, 32'he4);
      issue(moxie_pkg::OP_LDA_L, 11, 0, 32'he0);
      // No register dependency so far, only the slow bus can hold ready low
      check_ready(1'b0, ready_min);
      issue(moxie_pkg::OP_STA_L, 11, 0, 32'he8);
      issue(moxie_pkg::OP_LDA_L, 12, 0, 32'h80);
      issue(moxie_pkg::OP_DEC, 12, 0, 32'h10);
      issue(moxie_pkg::OP_STA_L, 12, 0, 32'hec);
      finish_test();
      ack_delay_force = -1;
    end
  endtask

  initial
  begin
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    ref_cc        = '0;
    for (int i = 0; i < `MOXIE_NREGS; i++)
      ref_regs[i] = '0;
    // Fill value depends on the full byte address of each word
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      bus_mem[i] = 32'h9e37_79b9 * (i * 4 + 1);
      ref_mem[i] = bus_mem[i];
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    reset_state();
    alu_ops();
    load_store();
    cond_branches();
    jumps();
    backpressure();
    $display("Summary: %0d tests, %0d instructions, %0d errors", n_tests, n_issued, n_errors);
    if (n_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== verilog/moxie_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Moxie back end top
// Decode, execute, memory stages and the register file
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "moxie_cfg.svh"

module moxie_core (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   instr_valid_i,
  input  moxie_pkg::instr_t      instr_i,
  output logic                   instr_ready_o,
  output moxie_pkg::branch_t     branch_o,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic                   wb_we_o,
  output logic [`MOXIE_XLEN-1:0] wb_adr_o,
  output logic [`MOXIE_XLEN-1:0] wb_dat_o,
  input  logic                   wb_ack_i,
  input  logic [`MOXIE_XLEN-1:0] wb_dat_i
);

  logic [`MOXIE_RIDX_W-1:0] rd_a_idx;
  logic [`MOXIE_RIDX_W-1:0] rd_b_idx;
  logic [`MOXIE_XLEN-1:0]   reg_a;
  logic [`MOXIE_XLEN-1:0]   reg_b;
  logic                     dx_stall;
  logic                     mem_busy;
  moxie_pkg::dx_t           dx;
  moxie_pkg::xm_t           xm;
  moxie_pkg::wb_t           wb;

  moxie_regfile u_regfile (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_a_idx_i (rd_a_idx),
    .rd_b_idx_i (rd_b_idx),
    .wb_i       (wb),
    .rd_a_o     (reg_a),
    .rd_b_o     (reg_b)
  );

  moxie_decode u_decode (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .reg_a_i       (reg_a),
    .reg_b_i       (reg_b),
    .dx_stall_i    (dx_stall),
    .pend_xm_i     (xm),
    .instr_ready_o (instr_ready_o),
    .rd_a_idx_o    (rd_a_idx),
    .rd_b_idx_o    (rd_b_idx),
    .dx_o          (dx)
  );

  moxie_execute u_execute (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .dx_i       (dx),
    .mem_busy_i (mem_busy),
    .dx_stall_o (dx_stall),
    .xm_o       (xm),
    .branch_o   (branch_o)
  );

  moxie_memory u_memory (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .xm_i       (xm),
    .wb_ack_i   (wb_ack_i),
    .wb_dat_i   (wb_dat_i),
    .mem_busy_o (mem_busy),
    .wb_o       (wb),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_we_o    (wb_we_o),
    .wb_adr_o   (wb_adr_o),
    .wb_dat_o   (wb_dat_o)
  );

endmodule

// ==== verilog/moxie_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Moxie decode stage
// Issue handshake, operand read and interlock against
// pending writes in execute and memory
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "moxie_cfg.svh"

module moxie_decode (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     instr_valid_i,
  input  moxie_pkg::instr_t        instr_i,
  input  logic [`MOXIE_XLEN-1:0]   reg_a_i,
  input  logic [`MOXIE_XLEN-1:0]   reg_b_i,
  input  logic                     dx_stall_i,
  input  moxie_pkg::xm_t           pend_xm_i,
  output logic                     instr_ready_o,
  output logic [`MOXIE_RIDX_W-1:0] rd_a_idx_o,
  output logic [`MOXIE_RIDX_W-1:0] rd_b_idx_o,
  output moxie_pkg::dx_t           dx_o
);

  logic use_a;
  logic use_b;
  logic dx_writes;
  logic xm_writes;
  logic hit_a;
  logic hit_b;
  logic dx_adv;
  logic fire;

  // Source registers read by each opcode
  always_comb
  begin
    use_a = 1'b0;
    use_b = 1'b0;
    case (instr_i.op)
      moxie_pkg::OP_ADD_L, moxie_pkg::OP_SUB_L, moxie_pkg::OP_AND,
      moxie_pkg::OP_OR, moxie_pkg::OP_XOR, moxie_pkg::OP_CMP:
      begin
        use_a = 1'b1;
        use_b = 1'b1;
      end
      moxie_pkg::OP_INC, moxie_pkg::OP_DEC, moxie_pkg::OP_STA_L: use_a = 1'b1;
      moxie_pkg::OP_MOV: use_b = 1'b1;
      default: ;
    endcase
  end

  // Whether the instruction sitting in dx will write rd
  always_comb
  begin
    case (dx_o.op)
      moxie_pkg::OP_ADD_L, moxie_pkg::OP_SUB_L, moxie_pkg::OP_AND,
      moxie_pkg::OP_OR, moxie_pkg::OP_XOR, moxie_pkg::OP_MOV,
      moxie_pkg::OP_LDI_L, moxie_pkg::OP_INC, moxie_pkg::OP_DEC,
      moxie_pkg::OP_LDA_L: dx_writes = dx_o.valid;
      default: dx_writes = 1'b0;
    endcase
  end

  assign xm_writes = pend_xm_i.valid && pend_xm_i.wr_en;

  assign hit_a = use_a && ((dx_writes && (dx_o.rd == instr_i.ra)) ||
                           (xm_writes && (pend_xm_i.rd == instr_i.ra)));
  assign hit_b = use_b && ((dx_writes && (dx_o.rd == instr_i.rb)) ||
                           (xm_writes && (pend_xm_i.rd == instr_i.rb)));

  assign dx_adv        = !dx_o.valid || !dx_stall_i;
  assign instr_ready_o = dx_adv && !hit_a && !hit_b;
  assign fire          = instr_valid_i && instr_ready_o;

  assign rd_a_idx_o = instr_i.ra;
  assign rd_b_idx_o = instr_i.rb;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      dx_o <= '0;
    end
    else if (dx_adv)
    begin
      dx_o.valid <= fire;
      dx_o.op    <= instr_i.op;
      dx_o.ra    <= instr_i.ra;
      dx_o.rd    <= instr_i.ra;
      dx_o.reg_a <= reg_a_i;
      dx_o.reg_b <= reg_b_i;
      dx_o.imm   <= instr_i.imm;
      dx_o.pc    <= instr_i.pc;
    end
  end

  // Execute must see the same record for as long as it stalls
  a_dx_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (dx_o.valid && dx_stall_i) |=> $stable(dx_o));

endmodule

// ==== verilog/moxie_execute.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Moxie execute stage
// ALU, condition codes, branch resolution with a one slot
// squash, and the execute to memory register
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "moxie_cfg.svh"

module moxie_execute (
  input  logic                clk_i,
  input  logic                rst_i,
  input  moxie_pkg::dx_t      dx_i,
  input  logic                mem_busy_i,
  output logic                dx_stall_o,
  output moxie_pkg::xm_t      xm_o,
  output moxie_pkg::branch_t  branch_o
);

  logic [`MOXIE_XLEN-1:0] a_sub_b;
  logic [`MOXIE_XLEN-1:0] b_sub_a;
  logic [`MOXIE_XLEN-1:0] rel_target;
  logic [`MOXIE_XLEN-1:0] br_target;
  logic [`MOXIE_PCREL_W-1:0] offset;
  moxie_pkg::cc_t cc_q;
  moxie_pkg::cc_t cc_d;
  moxie_pkg::xm_t xm_d;
  logic kill_q;
  logic live;
  logic taken;

  assign dx_stall_o = mem_busy_i;

  // Shadow slot of a taken branch is dropped here
  assign live = dx_i.valid && !kill_q;

  assign a_sub_b = dx_i.reg_a - dx_i.reg_b;
  assign b_sub_a = dx_i.reg_b - dx_i.reg_a;

  assign cc_d.eq = dx_i.reg_a == dx_i.reg_b;
  assign cc_d.lt = $signed(dx_i.reg_a) < $signed(dx_i.reg_b);
  assign cc_d.gt = $signed(dx_i.reg_a) > $signed(dx_i.reg_b);
  // Unsigned order: differing sign bits decide, else the difference sign
  assign cc_d.ltu = (dx_i.reg_a[`MOXIE_XLEN-1] ^ dx_i.reg_b[`MOXIE_XLEN-1]) ?
                    dx_i.reg_b[`MOXIE_XLEN-1] : a_sub_b[`MOXIE_XLEN-1];
  assign cc_d.gtu = (dx_i.reg_a[`MOXIE_XLEN-1] ^ dx_i.reg_b[`MOXIE_XLEN-1]) ?
                    dx_i.reg_a[`MOXIE_XLEN-1] : b_sub_a[`MOXIE_XLEN-1];

  // Halfword offset, sign extended
  assign offset     = dx_i.imm[`MOXIE_PCREL_W-1:0];
  assign rel_target = dx_i.pc + `MOXIE_PC_STEP +
                      {{(`MOXIE_XLEN-`MOXIE_PCREL_W-1){offset[`MOXIE_PCREL_W-1]}},
                       offset, 1'b0};

  always_comb
  begin
    xm_d            = '0;
    xm_d.valid      = live;
    xm_d.mem_op     = moxie_pkg::MEM_NONE;
    xm_d.rd         = dx_i.rd;
    xm_d.addr       = dx_i.imm;
    xm_d.store_data = dx_i.reg_a;
    taken           = 1'b0;
    br_target       = rel_target;
    case (dx_i.op)
      moxie_pkg::OP_ADD_L: xm_d.result = dx_i.reg_a + dx_i.reg_b;
      moxie_pkg::OP_SUB_L: xm_d.result = a_sub_b;
      moxie_pkg::OP_AND:   xm_d.result = dx_i.reg_a & dx_i.reg_b;
      moxie_pkg::OP_OR:    xm_d.result = dx_i.reg_a | dx_i.reg_b;
      moxie_pkg::OP_XOR:   xm_d.result = dx_i.reg_a ^ dx_i.reg_b;
      moxie_pkg::OP_MOV:   xm_d.result = dx_i.reg_b;
      moxie_pkg::OP_LDI_L: xm_d.result = dx_i.imm;
      moxie_pkg::OP_INC:   xm_d.result = dx_i.reg_a + dx_i.imm;
      moxie_pkg::OP_DEC:   xm_d.result = dx_i.reg_a - dx_i.imm;
      moxie_pkg::OP_LDA_L: xm_d.mem_op = moxie_pkg::MEM_LOAD;
      moxie_pkg::OP_STA_L: xm_d.mem_op = moxie_pkg::MEM_STORE;
      moxie_pkg::OP_BEQ:   taken = cc_q.eq;
      moxie_pkg::OP_BNE:   taken = !cc_q.eq;
      moxie_pkg::OP_BLT:   taken = cc_q.lt;
      moxie_pkg::OP_BGT:   taken = cc_q.gt;
      moxie_pkg::OP_BLTU:  taken = cc_q.ltu;
      moxie_pkg::OP_BGTU:  taken = cc_q.gtu;
      moxie_pkg::OP_JMPA:
      begin
        taken     = 1'b1;
        br_target = dx_i.imm;
      end
      default: ;
    endcase
    // Register writers, loads included
    case (dx_i.op)
      moxie_pkg::OP_ADD_L, moxie_pkg::OP_SUB_L, moxie_pkg::OP_AND,
      moxie_pkg::OP_OR, moxie_pkg::OP_XOR, moxie_pkg::OP_MOV,
      moxie_pkg::OP_LDI_L, moxie_pkg::OP_INC, moxie_pkg::OP_DEC,
      moxie_pkg::OP_LDA_L: xm_d.wr_en = 1'b1;
      default: xm_d.wr_en = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      xm_o     <= '0;
      branch_o <= '0;
      cc_q     <= '0;
      kill_q   <= 1'b0;
    end
    else
    begin
      branch_o.valid <= 1'b0;
      if (!mem_busy_i)
      begin
        xm_o <= xm_d;
        // Kill flag clears on the next consumed record, whatever its spacing
        if (dx_i.valid)
        begin
          kill_q <= live && taken;
        end
        if (live && taken)
        begin
          branch_o.valid  <= 1'b1;
          branch_o.target <= br_target;
        end
        if (live && (dx_i.op == moxie_pkg::OP_CMP))
        begin
          cc_q <= cc_d;
        end
      end
    end
  end

  a_branch_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    branch_o.valid |=> !branch_o.valid);

  a_xm_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_busy_i |=> $stable(xm_o));

endmodule

// ==== verilog/moxie_memory.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Moxie memory and writeback stage
// Wishbone classic master for word loads and stores,
// retires each record into the register file
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "moxie_cfg.svh"

module moxie_memory (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  moxie_pkg::xm_t         xm_i,
  input  logic                   wb_ack_i,
  input  logic [`MOXIE_XLEN-1:0] wb_dat_i,
  output logic                   mem_busy_o,
  output moxie_pkg::wb_t         wb_o,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic                   wb_we_o,
  output logic [`MOXIE_XLEN-1:0] wb_adr_o,
  output logic [`MOXIE_XLEN-1:0] wb_dat_o
);

  typedef enum logic {
    ST_IDLE,
    ST_BUS
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   is_mem;
  logic   is_load;
  logic   retire;

  assign is_mem  = xm_i.valid && (xm_i.mem_op != moxie_pkg::MEM_NONE);
  assign is_load = xm_i.mem_op == moxie_pkg::MEM_LOAD;

  // ALU records leave after one cycle, memory records on the ack edge
  assign retire = xm_i.valid &&
                  ((xm_i.mem_op == moxie_pkg::MEM_NONE) ||
                   ((state_q == ST_BUS) && wb_ack_i));

  assign mem_busy_o = xm_i.valid && !retire;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (is_mem) state_d = ST_BUS;
      ST_BUS:  if (wb_ack_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= ST_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Bus fields come straight from xm, which execute holds while busy
  assign wb_cyc_o = state_q == ST_BUS;
  assign wb_stb_o = state_q == ST_BUS;
  assign wb_we_o  = xm_i.mem_op == moxie_pkg::MEM_STORE;
  assign wb_adr_o = xm_i.addr;
  assign wb_dat_o = xm_i.store_data;

  assign wb_o.wr_en = retire && xm_i.wr_en;
  assign wb_o.rd    = xm_i.rd;
  assign wb_o.data  = is_load ? wb_dat_i : xm_i.result;

  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_stb_o |-> wb_cyc_o);

  a_we_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (wb_cyc_o && !wb_ack_i) |=> $stable(wb_we_o));

endmodule

// ==== verilog/moxie_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Moxie back end types
// Opcodes, condition codes and the records passed between stages
// ~~~~~~~~~~~~~~~~~~~~

`include "moxie_cfg.svh"

package moxie_pkg;

  // Supported opcodes, anything else runs as a NOP
  typedef enum logic [5:0] {
    OP_LDI_L = 6'h01,
    OP_MOV   = 6'h02,
    OP_ADD_L = 6'h05,
    OP_LDA_L = 6'h08,
    OP_STA_L = 6'h09,
    OP_CMP   = 6'h0e,
    OP_NOP   = 6'h0f,
    OP_JMPA  = 6'h1a,
    OP_AND   = 6'h26,
    OP_SUB_L = 6'h29,
    OP_OR    = 6'h2b,
    OP_XOR   = 6'h2e,
    OP_INC   = 6'h30,
    OP_DEC   = 6'h31,
    OP_BEQ   = 6'h38,
    OP_BNE   = 6'h39,
    OP_BLT   = 6'h3a,
    OP_BGT   = 6'h3b,
    OP_BLTU  = 6'h3c,
    OP_BGTU  = 6'h3d
  } opcode_e;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

  // Instruction as delivered by the fetch unit
  typedef struct packed {
    opcode_e                  op;
    logic [`MOXIE_RIDX_W-1:0] ra;
    logic [`MOXIE_RIDX_W-1:0] rb;
    logic [`MOXIE_XLEN-1:0]   imm;
    logic [`MOXIE_XLEN-1:0]   pc;
  } instr_t;

  typedef struct packed {
    logic eq;
    logic lt;
    logic gt;
    logic ltu;
    logic gtu;
  } cc_t;

  typedef struct packed {
    logic                     valid;
    opcode_e                  op;
    logic [`MOXIE_RIDX_W-1:0] ra;
    logic [`MOXIE_RIDX_W-1:0] rd;
    logic [`MOXIE_XLEN-1:0]   reg_a;
    logic [`MOXIE_XLEN-1:0]   reg_b;
    logic [`MOXIE_XLEN-1:0]   imm;
    logic [`MOXIE_XLEN-1:0]   pc;
  } dx_t;

  typedef struct packed {
    logic                     valid;
    mem_op_e                  mem_op;
    logic                     wr_en;
    logic [`MOXIE_RIDX_W-1:0] rd;
    logic [`MOXIE_XLEN-1:0]   result;
    logic [`MOXIE_XLEN-1:0]   addr;
    logic [`MOXIE_XLEN-1:0]   store_data;
  } xm_t;

  typedef struct packed {
    logic                     wr_en;
    logic [`MOXIE_RIDX_W-1:0] rd;
    logic [`MOXIE_XLEN-1:0]   data;
  } wb_t;

  typedef struct packed {
    logic                   valid;
    logic [`MOXIE_XLEN-1:0] target;
  } branch_t;

endpackage

// ==== verilog/moxie_regfile.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Moxie register file
// Sixteen words, two asynchronous reads, one clocked write
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "moxie_cfg.svh"

module moxie_regfile (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic [`MOXIE_RIDX_W-1:0] rd_a_idx_i,
  input  logic [`MOXIE_RIDX_W-1:0] rd_b_idx_i,
  input  moxie_pkg::wb_t           wb_i,
  output logic [`MOXIE_XLEN-1:0]   rd_a_o,
  output logic [`MOXIE_XLEN-1:0]   rd_b_o
);

  logic [`MOXIE_XLEN-1:0] regs [`MOXIE_NREGS];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      regs <= '{default: '0};
    end
    else if (wb_i.wr_en)
    begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // No bypass, decode waits until the write has landed
  assign rd_a_o = regs[rd_a_idx_i];
  assign rd_b_o = regs[rd_b_idx_i];

endmodule
